// File: build.f
verilog/cpu_pkg.sv
verilog/mem_port_if.sv
verilog/mem_access.sv
verilog/inst_fetch.sv
verilog/mem_arbiter.sv
verilog/mem_ctrl.sv
verilog/mem_sys_top.sv
verification/mem_sys_sva.sv
verification/mem_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_sys_tb -f build.f -o mem_sys_sim

out=$(./obj_dir/mem_sys_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: verification/mem_sys_sva.sv
`default_nettype none

module mem_sys_sva (
    input wire clk,
    input wire rst,
    input wire stall_i,
    input wire wb_en_i,
    input wire ctrl_req_i,
    input wire ctrl_we_i,
    input wire [cpu_pkg::addr_w-1:0] ctrl_addr_i,
    input wire cpu_pkg::mem_size_t ctrl_size_i,
    input wire [cpu_pkg::xlen-1:0] ctrl_wdata_i,
    input wire ctrl_done_i,
    input wire grant_data_i,
    input wire grant_fetch_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // consecutive stall cycles seen so far.
    logic [5:0] stall_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_cnt <= '0;
        end else if (stall_i) begin
            stall_cnt <= stall_cnt + 6'd1;
        end else begin
            stall_cnt <= '0;
        end
    end

    // a stalled stage must not write a register.
    no_wreg_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall_i |-> !wb_en_i)
        else $error("wreg_o high while mem_stall_o is high");

    // the stall has to end within 40 cycles.
    stall_bounded: assert property (@(posedge clk) disable iff (rst)
        stall_cnt < 6'd40)
        else $error("mem_stall_o stayed high for 40 cycles");

    // controller request held until its done cycle.
    ctrl_req_held: assert property (@(posedge clk) disable iff (rst)
        (ctrl_req_i && !ctrl_done_i) |=> (ctrl_req_i && $stable(ctrl_we_i)
        && $stable(ctrl_addr_i) && $stable(ctrl_size_i) && $stable(ctrl_wdata_i)))
        else $error("controller request changed before done");

    // a data grant stays locked, fetch gets nothing until done.
    one_grant: assert property (@(posedge clk) disable iff (rst)
        (grant_data_i && !ctrl_done_i) |=> !grant_fetch_i)
        else $error("fetch granted while a data access was in flight");

    // same lock the other way round.
    one_grant_fetch: assert property (@(posedge clk) disable iff (rst)
        (grant_fetch_i && !ctrl_done_i) |=> !grant_data_i)
        else $error("data granted while a fetch access was in flight");

endmodule

bind mem_sys_top mem_sys_sva sva0 (
    .clk(clk),
    .rst(rst),
    .stall_i(mem_stall_o),
    .wb_en_i(wreg_o),
    .ctrl_req_i(ctrl_port.req),
    .ctrl_we_i(ctrl_port.we),
    .ctrl_addr_i(ctrl_port.addr),
    .ctrl_size_i(ctrl_port.size),
    .ctrl_wdata_i(ctrl_port.wdata),
    .ctrl_done_i(ctrl_port.done),
    .grant_data_i(mem_arbiter0.grant_data),
    .grant_fetch_i(mem_arbiter0.grant_fetch)
);

`default_nettype wire

// File: verification/mem_sys_tb.sv
`default_nettype none

module mem_sys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // test lengths, counted in memory operations.
    localparam int n_pass = 8;
    localparam int n_words = 16;
    localparam int n_sign_ops = 26;
    localparam int n_rounds = 4;
    localparam int n_fetch_words = 48;
    localparam int n_fetch_check = 8;
    localparam int n_contend = 8;
    localparam int n_ops = n_pass + 2 * n_words + n_sign_ops + 4 * n_rounds
        + n_fetch_words + n_fetch_check + n_contend;
    // 40 cycles per operation is far above any single access.
    localparam int max_cycles = 40 * n_ops + 200;

    // fetched words live above the data region (0x000 to 0x1ff).
    localparam logic [31:0] fetch_base = 32'h0000_0200;

    logic clk;
    logic rst;
    logic [cpu_pkg::reg_addr_w-1:0] wd_i;
    logic wreg_i;
    logic [cpu_pkg::xlen-1:0] wdata_i;
    logic [cpu_pkg::addr_w-1:0] memaddr_i;
    logic memwr_i;
    cpu_pkg::mem_size_t memcnf_i;
    logic memsigned_i;
    logic [cpu_pkg::reg_addr_w-1:0] wd_o;
    logic wreg_o;
    logic [cpu_pkg::xlen-1:0] wdata_o;
    logic mem_stall_o;
    logic start_i;
    logic [cpu_pkg::addr_w-1:0] start_pc_i;
    logic [cpu_pkg::xlen-1:0] inst_o;
    logic [cpu_pkg::addr_w-1:0] pc_o;
    logic inst_valid_o;

    // byte image of the 1 KiB ram, only written locations are read back.
    logic [7:0] shadow [1024];
    integer seed = 32'h18c8_15eb;
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    // fetched words checked so far.
    int fetch_seen = 0;
    logic fetch_checking;

    mem_sys_top dut0 (
        .clk(clk),
        .rst(rst),
        .wd_i(wd_i),
        .wreg_i(wreg_i),
        .wdata_i(wdata_i),
        .memaddr_i(memaddr_i),
        .memwr_i(memwr_i),
        .memcnf_i(memcnf_i),
        .memsigned_i(memsigned_i),
        .wd_o(wd_o),
        .wreg_o(wreg_o),
        .wdata_o(wdata_o),
        .mem_stall_o(mem_stall_o),
        .start_i(start_i),
        .start_pc_i(start_pc_i),
        .inst_o(inst_o),
        .pc_o(pc_o),
        .inst_valid_o(inst_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    function automatic int byte_count(input cpu_pkg::mem_size_t size);
        case (size)
            cpu_pkg::mem_byte: return 1;
            cpu_pkg::mem_half: return 2;
            default: return 4;
        endcase
    endfunction

    // expected load result from the shadow bytes, little endian.
    function automatic logic [31:0] expect_load(input cpu_pkg::mem_size_t size,
                                                input logic sgn, input logic [31:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = shadow[10'(addr)];
        b1 = shadow[10'(addr + 32'd1)];
        b2 = shadow[10'(addr + 32'd2)];
        b3 = shadow[10'(addr + 32'd3)];
        case (size)
            cpu_pkg::mem_byte: return {{24{sgn & b0[7]}}, b0};
            cpu_pkg::mem_half: return {{16{sgn & b1[7]}}, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    // a bubble-free idle stage.
    task automatic drive_idle();
        wd_i = '0;
        wreg_i = 1'b0;
        wdata_i = '0;
        memaddr_i = '0;
        memwr_i = 1'b0;
        memcnf_i = cpu_pkg::mem_none;
        memsigned_i = 1'b0;
    endtask

    // called just after a rising edge, returns just after the edge that ends the access.
    task automatic run_access(input logic wr, input cpu_pkg::mem_size_t size,
                              input logic sgn, input logic [31:0] addr,
                              input logic [31:0] data, input logic [4:0] wd,
                              output logic [31:0] got_data, output logic got_wreg,
                              output logic [4:0] got_wd);
        wd_i = wd;
        wreg_i = 1'b1;
        wdata_i = data;
        memaddr_i = addr;
        memwr_i = wr;
        memcnf_i = size;
        memsigned_i = sgn;
        @(negedge clk);
        while (mem_stall_o) begin
            @(negedge clk);
        end
        // stall just fell, this is the result cycle.
        got_data = wdata_o;
        got_wreg = wreg_o;
        got_wd = wd_o;
        @(posedge clk);
        #1;
        drive_idle();
    endtask

    task automatic store(input cpu_pkg::mem_size_t size, input logic [31:0] addr,
                         input logic [31:0] data);
        logic [31:0] got_data;
        logic got_wreg;
        logic [4:0] got_wd;
        logic [31:0] r;
        int i;
        for (i = 0; i < byte_count(size); i++) begin
            shadow[10'(addr + 32'(i))] = data[8*i +: 8];
        end
        r = $random(seed);
        run_access(1'b1, size, 1'b0, addr, data, r[4:0], got_data, got_wreg, got_wd);
        // stores never write the register file.
        check_value("wreg_o", {31'd0, got_wreg}, 32'd0);
    endtask

    task automatic load_check(input cpu_pkg::mem_size_t size, input logic sgn,
                              input logic [31:0] addr);
        logic [31:0] got_data;
        logic got_wreg;
        logic [4:0] got_wd;
        logic [31:0] r;
        r = $random(seed);
        run_access(1'b0, size, sgn, addr, 32'd0, r[4:0], got_data, got_wreg, got_wd);
        check_value("wdata_o", got_data, expect_load(size, sgn, addr));
        check_value("wreg_o", {31'd0, got_wreg}, 32'd1);
        check_value("wd_o", {27'd0, got_wd}, {27'd0, r[4:0]});
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    // each fetched word must come from the next pc in order.
    always @(negedge clk) begin
        if (fetch_checking && inst_valid_o) begin
            check_value("pc_o", pc_o, fetch_base + 32'(4 * fetch_seen));
            check_value("inst_o", inst_o,
                        expect_load(cpu_pkg::mem_word, 1'b0, fetch_base + 32'(4 * fetch_seen)));
            fetch_seen = fetch_seen + 1;
        end
    end

    initial begin
        while (cycles <= max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run passed %0d cycles without finishing", max_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int i;
        int p;
        int off;
        int err0;
        int seen0;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] pattern;
        logic [31:0] word_addrs [n_words];
        rst = 1'b1;
        start_i = 1'b0;
        start_pc_i = '0;
        fetch_checking = 1'b0;
        drive_idle();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // 1. non-memory instructions pass straight through.
        err0 = errors;
        @(negedge clk);
        check_value("mem_stall_o", {31'd0, mem_stall_o}, 32'd0);
        check_value("inst_valid_o", {31'd0, inst_valid_o}, 32'd0);
        check_value("wreg_o", {31'd0, wreg_o}, 32'd0);
        @(posedge clk);
        #1;
        for (i = 0; i < n_pass; i++) begin
            r = $random(seed);
            wd_i = r[4:0];
            wreg_i = r[5];
            memwr_i = r[6];
            memsigned_i = r[7];
            wdata_i = $random(seed);
            memaddr_i = $random(seed);
            memcnf_i = cpu_pkg::mem_none;
            @(negedge clk);
            check_value("wd_o", {27'd0, wd_o}, {27'd0, wd_i});
            check_value("wreg_o", {31'd0, wreg_o}, {31'd0, wreg_i});
            check_value("wdata_o", wdata_o, wdata_i);
            check_value("mem_stall_o", {31'd0, mem_stall_o}, 32'd0);
            @(posedge clk);
            #1;
        end
        drive_idle();
        report_test("test 1 pass-through", err0);

        // 2. random words to random aligned addresses, then read back.
        err0 = errors;
        for (i = 0; i < n_words; i++) begin
            r = $random(seed);
            word_addrs[i] = {23'd0, r[8:2], 2'b00};
            store(cpu_pkg::mem_word, word_addrs[i], $random(seed));
        end
        for (i = 0; i < n_words; i++) begin
            load_check(cpu_pkg::mem_word, 1'b0, word_addrs[i]);
        end
        report_test("test 2 word store and load", err0);

        // 3. byte and half loads over words with both signs in each lane.
        err0 = errors;
        for (p = 0; p < 2; p++) begin
            pattern = (p == 0) ? 32'h8081_7f70 : 32'h12ff_c355;
            r = $random(seed);
            a = {23'd0, r[8:2], 2'b00};
            store(cpu_pkg::mem_word, a, pattern);
            for (off = 0; off < 4; off++) begin
                load_check(cpu_pkg::mem_byte, 1'b0, a + 32'(off));
                load_check(cpu_pkg::mem_byte, 1'b1, a + 32'(off));
            end
            for (off = 0; off < 4; off += 2) begin
                load_check(cpu_pkg::mem_half, 1'b0, a + 32'(off));
                load_check(cpu_pkg::mem_half, 1'b1, a + 32'(off));
            end
        end
        report_test("test 3 byte and half loads", err0);

        // 4. narrow stores touch only their own bytes.
        err0 = errors;
        for (i = 0; i < n_rounds; i++) begin
            r = $random(seed);
            a = {23'd0, r[8:2], 2'b00};
            store(cpu_pkg::mem_word, a, $random(seed));
            r = $random(seed);
            store(cpu_pkg::mem_byte, a + {30'd0, r[1:0]}, r);
            r = $random(seed);
            store(cpu_pkg::mem_half, a + {30'd0, r[1], 1'b0}, r);
            load_check(cpu_pkg::mem_word, 1'b0, a);
        end
        report_test("test 4 byte and half stores", err0);

        // 5. fill the fetch region, then let the fetcher walk it.
        err0 = errors;
        for (i = 0; i < n_fetch_words; i++) begin
            store(cpu_pkg::mem_word, fetch_base + 32'(4 * i), $random(seed));
        end
        fetch_checking = 1'b1;
        start_pc_i = fetch_base;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        while (fetch_seen < n_fetch_check) begin
            @(posedge clk);
        end
        #1;
        report_test("test 5 fetch", err0);

        // 6. data accesses while the fetcher keeps asking.
        err0 = errors;
        seen0 = fetch_seen;
        for (i = 0; i < n_contend / 2; i++) begin
            r = $random(seed);
            a = {23'd0, r[8:2], 2'b00};
            store(cpu_pkg::mem_word, a, $random(seed));
            // an idle gap lets fetch win the next arbitration.
            repeat (int'(r[1:0]) + 1) @(posedge clk);
            #1;
            load_check((i % 2 == 1) ? cpu_pkg::mem_half : cpu_pkg::mem_word, 1'b1, a);
        end
        check_true(fetch_seen > seen0, "fetch made no progress during data accesses");
        fetch_checking = 1'b0;
        report_test("test 6 contention", err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // data word width of the core.
    localparam int xlen = 32;

    // register index width.
    localparam int reg_addr_w = 5;

    // byte address width.
    localparam int addr_w = 32;

    // access size, same coding as memcnf in the pipeline.
    // none means the instruction does not touch memory.
    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_byte = 2'd1,
        mem_half = 2'd2,
        mem_word = 2'd3
    } mem_size_t;

    // fetch pc before the first start.
    localparam logic [addr_w-1:0] pc_rst = '0;

    // number of bytes moved for one access size.
    function automatic logic [2:0] size_bytes(input mem_size_t size);
        logic [2:0] n;
        case (size)
            mem_byte: n = 3'd1;
            mem_half: n = 3'd2;
            mem_word: n = 3'd4;
            default: n = 3'd0;
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// File: verilog/inst_fetch.sv
`default_nettype none

module inst_fetch (
    input wire clk,
    input wire rst,

    // start fetching at start_pc_i.
    input wire start_i,
    input wire [cpu_pkg::addr_w-1:0] start_pc_i,

    // instruction side request towards the arbiter.
    mem_port_if.requester fport,

    output logic [cpu_pkg::xlen-1:0] inst_o,
    output logic [cpu_pkg::addr_w-1:0] pc_o,
    output logic inst_valid_o
);

    // one instruction word ahead.
    localparam logic [cpu_pkg::addr_w-1:0] word_step = 4;

    logic running_q;
    logic [cpu_pkg::addr_w-1:0] pc_q;
    logic can_start;

    // a new start is only taken between requests.
    assign can_start = !running_q || fport.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            running_q <= 1'b0;
            pc_q <= cpu_pkg::pc_rst;
        end else if (start_i && can_start) begin
            running_q <= 1'b1;
            pc_q <= start_pc_i;
        end else if (fport.done) begin
            pc_q <= pc_q + word_step;
        end
    end

    // word reads only, the pc register doubles as the held address.
    assign fport.req = running_q;
    assign fport.we = 1'b0;
    assign fport.addr = pc_q;
    assign fport.size = cpu_pkg::mem_word;
    assign fport.wdata = '0;

    // nothing is registered, the word is valid in the done cycle only.
    assign inst_o = fport.rdata;
    assign pc_o = pc_q;
    assign inst_valid_o = fport.done;

endmodule

`default_nettype wire

// File: verilog/mem_access.sv
`default_nettype none

module mem_access (
    input wire clk,
    input wire rst,

    // from the execute stage.
    input wire [cpu_pkg::reg_addr_w-1:0] wd_i,
    input wire wreg_i,
    input wire [cpu_pkg::xlen-1:0] wdata_i,
    input wire [cpu_pkg::addr_w-1:0] memaddr_i,
    // 0 for load, 1 for store.
    input wire memwr_i,
    input wire cpu_pkg::mem_size_t memcnf_i,
    // only meaningful for loads.
    input wire memsigned_i,

    // data side request towards the arbiter.
    mem_port_if.requester dport,

    // to writeback.
    output logic [cpu_pkg::reg_addr_w-1:0] wd_o,
    output logic wreg_o,
    output logic [cpu_pkg::xlen-1:0] wdata_o,

    output logic mem_stall_o
);

    logic is_mem;
    // set once the request is out and still waiting for done.
    logic pending_q;

    // request fields frozen after the first cycle.
    logic we_q;
    logic [cpu_pkg::addr_w-1:0] addr_q;
    cpu_pkg::mem_size_t size_q;
    logic [cpu_pkg::xlen-1:0] wdata_q;

    cpu_pkg::mem_size_t cur_size;
    logic [cpu_pkg::xlen-1:0] load_data;

    assign is_mem = (memcnf_i != cpu_pkg::mem_none);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (dport.done) begin
            pending_q <= 1'b0;
        end else if (is_mem) begin
            pending_q <= 1'b1;
        end
    end

    // capture in the first cycle, then hold for the rest of the access.
    always_ff @(posedge clk) begin
        if (!pending_q) begin
            we_q <= memwr_i;
            addr_q <= memaddr_i;
            size_q <= memcnf_i;
            wdata_q <= wdata_i;
        end
    end

    // first cycle comes straight from the inputs, later cycles from the capture.
    assign cur_size = pending_q ? size_q : memcnf_i;

    assign dport.req = pending_q | is_mem;
    assign dport.we = pending_q ? we_q : memwr_i;
    assign dport.addr = pending_q ? addr_q : memaddr_i;
    assign dport.size = cur_size;
    assign dport.wdata = pending_q ? wdata_q : wdata_i;

    // load extension, the half extends from bit 15.
    always_comb begin
        case (cur_size)
            cpu_pkg::mem_byte: begin
                load_data = {{24{memsigned_i & dport.rdata[7]}}, dport.rdata[7:0]};
            end
            cpu_pkg::mem_half: begin
                load_data = {{16{memsigned_i & dport.rdata[15]}}, dport.rdata[15:0]};
            end
            default: begin
                load_data = dport.rdata;
            end
        endcase
    end

    always_comb begin
        // non-memory instruction goes straight through.
        wd_o = wd_i;
        wreg_o = wreg_i;
        wdata_o = wdata_i;
        mem_stall_o = 1'b0;
        if (is_mem) begin
            if (dport.done) begin
                // result cycle, a store writes no register.
                wreg_o = wreg_i & ~memwr_i;
                if (!memwr_i) begin
                    wdata_o = load_data;
                end
            end else begin
                // bubble while the access is in flight.
                wreg_o = 1'b0;
                wdata_o = '0;
                mem_stall_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input wire clk,
    input wire rst,

    // data side, wins when both ask in the same cycle.
    mem_port_if.server data_s,
    // instruction side.
    mem_port_if.server fetch_s,

    // shared path to the controller.
    mem_port_if.requester ctrl_m
);

    // an access is in flight, owner stays fixed until done.
    logic busy_q;
    // 1 when the data side owns the controller.
    logic owner_q;

    logic sel_data;
    logic grant_data;
    logic grant_fetch;

    // idle picks by priority, busy keeps the locked owner.
    assign sel_data = busy_q ? owner_q : data_s.req;

    assign grant_data = sel_data & data_s.req;
    assign grant_fetch = ~sel_data & fetch_s.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            owner_q <= 1'b0;
        end else if (ctrl_m.done) begin
            busy_q <= 1'b0;
        end else if (!busy_q && ctrl_m.req) begin
            busy_q <= 1'b1;
            owner_q <= sel_data;
        end
    end

    // steering is combinational, no cycle is added.
    assign ctrl_m.req = grant_data | grant_fetch;
    assign ctrl_m.we = sel_data ? data_s.we : fetch_s.we;
    assign ctrl_m.addr = sel_data ? data_s.addr : fetch_s.addr;
    assign ctrl_m.size = sel_data ? data_s.size : fetch_s.size;
    assign ctrl_m.wdata = sel_data ? data_s.wdata : fetch_s.wdata;

    // read data is shared, done only reaches the owner.
    assign data_s.rdata = ctrl_m.rdata;
    assign fetch_s.rdata = ctrl_m.rdata;
    assign data_s.done = ctrl_m.done & sel_data;
    assign fetch_s.done = ctrl_m.done & ~sel_data;

endmodule

`default_nettype wire

// File: verilog/mem_ctrl.sv
`default_nettype none

module mem_ctrl #(
    parameter int ram_addr_w = 10
) (
    input wire clk,
    input wire rst,

    mem_port_if.server cport
);

    localparam int ram_depth = 1 << ram_addr_w;

    // byte wide synchronous ram.
    logic [7:0] ram [ram_depth];
    logic [7:0] ram_q;

    logic busy_q;
    // byte step within the access, runs up to the byte count.
    logic [2:0] cnt_q;

    // captured request.
    logic we_q;
    logic [ram_addr_w-1:0] addr_q;
    cpu_pkg::mem_size_t size_q;
    logic [cpu_pkg::xlen-1:0] wdata_q;

    // read bytes gathered so far.
    logic [cpu_pkg::xlen-1:0] asm_q;
    logic [cpu_pkg::xlen-1:0] rdata_c;

    logic [2:0] nbytes;
    logic [1:0] last_byte;
    logic [1:0] prev_byte;
    logic [ram_addr_w-1:0] byte_idx;
    logic access;

    assign nbytes = cpu_pkg::size_bytes(size_q);
    assign last_byte = 2'(nbytes - 3'd1);
    assign prev_byte = 2'(cnt_q - 3'd1);

    // addresses wrap at the ram depth.
    assign byte_idx = addr_q + ram_addr_w'(cnt_q);
    assign access = busy_q && (cnt_q < nbytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q <= 3'd0;
        end else if (!busy_q) begin
            if (cport.req) begin
                busy_q <= 1'b1;
                cnt_q <= 3'd0;
            end
        end else if (cport.done) begin
            busy_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && cport.req) begin
            we_q <= cport.we;
            addr_q <= cport.addr[ram_addr_w-1:0];
            size_q <= cport.size;
            wdata_q <= cport.wdata;
            asm_q <= '0;
        end else if (busy_q && cnt_q != 3'd0) begin
            // byte read one step earlier has just left the ram.
            asm_q[8*prev_byte +: 8] <= ram_q;
        end
    end

    // least significant byte first.
    always_ff @(posedge clk) begin
        if (access && we_q) begin
            ram[byte_idx] <= wdata_q[8*cnt_q[1:0] +: 8];
        end
        ram_q <= ram[byte_idx];
    end

    // last byte is still on the ram output in the done cycle.
    always_comb begin
        rdata_c = asm_q;
        rdata_c[8*last_byte +: 8] = ram_q;
    end

    assign cport.rdata = rdata_c;
    // size_bytes+1 cycles after acceptance.
    assign cport.done = busy_q && (cnt_q == nbytes);

endmodule

`default_nettype wire

// File: verilog/mem_port_if.sv
`default_nettype none

interface mem_port_if;

    // request level, held until the done cycle.
    logic req;
    // 1 for store, 0 for load.
    logic we;
    logic [cpu_pkg::addr_w-1:0] addr;
    cpu_pkg::mem_size_t size;
    logic [cpu_pkg::xlen-1:0] wdata;

    // read data, valid only while done is high.
    logic [cpu_pkg::xlen-1:0] rdata;
    // one-cycle completion pulse.
    logic done;

    // side that asks for an access.
    modport requester (
        output req, we, addr, size, wdata,
        input rdata, done
    );

    // side that carries out the access.
    modport server (
        input req, we, addr, size, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

// File: verilog/mem_sys_top.sv
`default_nettype none

module mem_sys_top #(
    parameter int ram_addr_w = 10
) (
    input wire clk,
    input wire rst,

    // memory stage of the pipeline.
    input wire [cpu_pkg::reg_addr_w-1:0] wd_i,
    input wire wreg_i,
    input wire [cpu_pkg::xlen-1:0] wdata_i,
    input wire [cpu_pkg::addr_w-1:0] memaddr_i,
    input wire memwr_i,
    input wire cpu_pkg::mem_size_t memcnf_i,
    input wire memsigned_i,
    output logic [cpu_pkg::reg_addr_w-1:0] wd_o,
    output logic wreg_o,
    output logic [cpu_pkg::xlen-1:0] wdata_o,
    output logic mem_stall_o,

    // instruction fetch.
    input wire start_i,
    input wire [cpu_pkg::addr_w-1:0] start_pc_i,
    output logic [cpu_pkg::xlen-1:0] inst_o,
    output logic [cpu_pkg::addr_w-1:0] pc_o,
    output logic inst_valid_o
);

    mem_port_if fetch_port ();
    mem_port_if data_port ();
    mem_port_if ctrl_port ();

    mem_access mem_access0 (
        .clk(clk),
        .rst(rst),
        .wd_i(wd_i),
        .wreg_i(wreg_i),
        .wdata_i(wdata_i),
        .memaddr_i(memaddr_i),
        .memwr_i(memwr_i),
        .memcnf_i(memcnf_i),
        .memsigned_i(memsigned_i),
        .dport(data_port),
        .wd_o(wd_o),
        .wreg_o(wreg_o),
        .wdata_o(wdata_o),
        .mem_stall_o(mem_stall_o)
    );

    inst_fetch inst_fetch0 (
        .clk(clk),
        .rst(rst),
        .start_i(start_i),
        .start_pc_i(start_pc_i),
        .fport(fetch_port),
        .inst_o(inst_o),
        .pc_o(pc_o),
        .inst_valid_o(inst_valid_o)
    );

    // data side has priority over fetch.
    mem_arbiter mem_arbiter0 (
        .clk(clk),
        .rst(rst),
        .data_s(data_port),
        .fetch_s(fetch_port),
        .ctrl_m(ctrl_port)
    );

    mem_ctrl #(
        .ram_addr_w(ram_addr_w)
    ) mem_ctrl0 (
        .clk(clk),
        .rst(rst),
        .cport(ctrl_port)
    );

endmodule

`default_nettype wire
